/* common/saturnPkg.sv */
`default_nettype none

package saturnPkg;

	// CPU bus widths
	typedef logic [24:0] addrT;
	typedef logic [31:0] dataT;
	typedef logic [3:0]  dqmT;

	// System manager register byte
	typedef logic [7:0] smpcDataT;

	// Debug access length
	typedef logic [7:0] waitCntT;

	// Rising phase enables per SMPC tick
	localparam int smpcDivide = 7;

	// Hook address in high work RAM
	localparam addrT hookAddr = 25'h00012B0;

	// Current holder of the master CPU bus
	typedef enum logic [1:0] {
		ownerMaster = 2'd0,
		ownerSlave  = 2'd1,
		ownerScu    = 2'd2
	} busOwnerE;

endpackage

`default_nettype wire

/* common/cpuBusIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface cpuBusIf import saturnPkg::*; ();

	addrT addr;
	logic rdN;
	dqmT  dqmN;
	logic cs3N;

	// High work RAM select only
	modport router (
		input cs3N
	);

	modport monitor (
		input addr,
		input rdN,
		input dqmN,
		input cs3N
	);

endinterface

`default_nettype wire

/* verilog/clockEnables.sv */
`timescale 1ns/10ps
`default_nettype none

module clockEnables import saturnPkg::*; (
	input  wire  CLK,
	input  wire  RST_N,
	input  wire  ce,
	input  wire  pauseEn,
	output logic ceRise,
	output logic ceFall,
	output logic smpcTick,
	output logic smpcResetN
);

	logic                          phase;
	logic [$clog2(smpcDivide)-1:0] divCnt;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			phase <= 1'b0;
		end else if (ce && !pauseEn) begin
			phase <= ~phase;
		end
	end

	assign ceRise =  phase & ~pauseEn;
	assign ceFall = ~phase & ~pauseEn;

	// SMPC clock is the CPU phase rate divided down
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			divCnt     <= '0;
			smpcTick   <= 1'b0;
			smpcResetN <= 1'b0;
		end else begin
			smpcTick <= 1'b0;
			if (ceRise) begin
				if (int'(divCnt) == smpcDivide - 1) begin
					divCnt   <= '0;
					smpcTick <= 1'b1;
				end else begin
					divCnt <= divCnt + 1'b1;
				end
			end
			// Manager leaves reset once it has been clocked
			if (smpcTick) smpcResetN <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* bus/busArbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module busArbiter import saturnPkg::*; (
	input  wire  CLK,
	input  wire  RST_N,
	input  wire  ceRise,
	input  wire  sshBusReqN,
	input  wire  scuBusReqN,
	input  wire  masterGrantN,
	output logic masterReleaseN,
	output logic sshAckN,
	output logic scuAckN
);

	busOwnerE owner;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			owner <= ownerMaster;
		end else if (ceRise) begin
			case (owner)
				ownerMaster: begin
					// Slave CPU has priority over the SCU
					if (!sshBusReqN) begin
						owner <= ownerSlave;
					end else if (!scuBusReqN) begin
						owner <= ownerScu;
					end
				end
				ownerSlave: begin
					if (sshBusReqN) owner <= ownerMaster;
				end
				ownerScu: begin
					if (scuBusReqN) owner <= ownerMaster;
				end
				default: begin
					owner <= ownerMaster;
				end
			endcase
		end
	end

	// Ask the master to let go while the owner still wants the bus
	assign masterReleaseN = ~((owner == ownerSlave && !sshBusReqN) ||
	                          (owner == ownerScu && !scuBusReqN));

	assign sshAckN = masterGrantN | (owner != ownerSlave);
	assign scuAckN = masterGrantN | (owner != ownerScu);

endmodule

`default_nettype wire

/* bus/busRouter.sv */
`timescale 1ns/10ps
`default_nettype none

module busRouter import saturnPkg::*; (
	cpuBusIf.router      bus,
	input  wire          lowRamSelN,
	input  wire          romSelN,
	input  wire          sramSelN,
	input  wire          smpcSelN,
	input  wire dataT    memDi,
	input  wire smpcDataT smpcDo,
	input  wire dataT    scuDo,
	input  wire          memWaitN,
	input  wire          scuWaitN,
	output dataT         cpuReadData,
	output logic         cpuWaitN
);

	logic memSel;

	// Work RAM high/low, ROM and backup SRAM all sit on external memory
	assign memSel = !bus.cs3N || !lowRamSelN || !romSelN || !sramSelN;

	always_comb begin
		if (memSel) begin
			cpuReadData = memDi;
		end else if (!smpcSelN) begin
			// Byte wide device, mirrored on every lane
			cpuReadData = {4{smpcDo}};
		end else begin
			cpuReadData = scuDo;
		end
	end

	// Memory wait ignored unless memory is addressed
	assign cpuWaitN = scuWaitN & (memWaitN | ~memSel);

endmodule

`default_nettype wire

/* verilog/debugMonitor.sv */
`timescale 1ns/10ps
`default_nettype none

module debugMonitor import saturnPkg::*; (
	input  wire      CLK,
	input  wire      RST_N,
	input  wire      ceRise,
	cpuBusIf.monitor bus,
	output waitCntT  dbgWaitCnt,
	output logic     dbgHook
);

	logic accessActive;

	// Read strobe or any byte lane enabled
	assign accessActive = !bus.rdN || !(&bus.dqmN);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dbgWaitCnt <= '0;
			dbgHook    <= 1'b0;
		end else if (ceRise) begin
			if (accessActive) begin
				dbgWaitCnt <= dbgWaitCnt + waitCntT'(1);
			end else begin
				dbgWaitCnt <= '0;
			end
			// Sticky until reset
			if (bus.addr == hookAddr && !bus.rdN && !bus.cs3N) begin
				dbgHook <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/saturnGlue.sv */
`timescale 1ns/10ps
`default_nettype none

module saturnGlue import saturnPkg::*; (
	input  wire           CLK,
	input  wire           RST_N,
	input  wire           ce,
	input  wire           pauseEn,

	input  wire           sshBusReqN,
	input  wire           scuBusReqN,
	input  wire           masterGrantN,

	input  wire addrT     cpuAddr,
	input  wire           cpuRdN,
	input  wire dqmT      cpuDqmN,
	input  wire           cs3N,
	input  wire           lowRamSelN,
	input  wire           romSelN,
	input  wire           sramSelN,
	input  wire           smpcSelN,
	input  wire dataT     memDi,
	input  wire smpcDataT smpcDo,
	input  wire dataT     scuDo,
	input  wire           memWaitN,
	input  wire           scuWaitN,

	output logic          ceRise,
	output logic          ceFall,
	output logic          smpcTick,
	output logic          smpcResetN,
	output logic          masterReleaseN,
	output logic          sshAckN,
	output logic          scuAckN,
	output dataT          cpuReadData,
	output logic          cpuWaitN,
	output waitCntT       dbgWaitCnt,
	output logic          dbgHook
);

	cpuBusIf cpuBus ();

	// Master CPU access onto the shared bus bundle
	assign cpuBus.addr = cpuAddr;
	assign cpuBus.rdN  = cpuRdN;
	assign cpuBus.dqmN = cpuDqmN;
	assign cpuBus.cs3N = cs3N;

	clockEnables clockEnables (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.ce         (ce),
		.pauseEn    (pauseEn),
		.ceRise     (ceRise),
		.ceFall     (ceFall),
		.smpcTick   (smpcTick),
		.smpcResetN (smpcResetN)
	);

	busArbiter busArbiter (
		.CLK            (CLK),
		.RST_N          (RST_N),
		.ceRise         (ceRise),
		.sshBusReqN     (sshBusReqN),
		.scuBusReqN     (scuBusReqN),
		.masterGrantN   (masterGrantN),
		.masterReleaseN (masterReleaseN),
		.sshAckN        (sshAckN),
		.scuAckN        (scuAckN)
	);

	busRouter busRouter (
		.bus         (cpuBus.router),
		.lowRamSelN  (lowRamSelN),
		.romSelN     (romSelN),
		.sramSelN    (sramSelN),
		.smpcSelN    (smpcSelN),
		.memDi       (memDi),
		.smpcDo      (smpcDo),
		.scuDo       (scuDo),
		.memWaitN    (memWaitN),
		.scuWaitN    (scuWaitN),
		.cpuReadData (cpuReadData),
		.cpuWaitN    (cpuWaitN)
	);

	debugMonitor debugMonitor (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.ceRise     (ceRise),
		.bus        (cpuBus.monitor),
		.dbgWaitCnt (dbgWaitCnt),
		.dbgHook    (dbgHook)
	);

endmodule

`default_nettype wire

/* test/tbSaturnGlue.sv */
`timescale 1ns/10ps
`default_nettype none

module tbSaturnGlue import saturnPkg::*; ();

	localparam int timeoutCycles = 4000;

	logic CLK, RST_N, ce, pauseEn;
	logic sshBusReqN, scuBusReqN, masterGrantN;
	addrT cpuAddr;
	logic cpuRdN;
	dqmT  cpuDqmN;
	logic cs3N, lowRamSelN, romSelN, sramSelN, smpcSelN;
	dataT memDi, scuDo;
	smpcDataT smpcDo;
	logic memWaitN, scuWaitN;
	logic ceRise, ceFall, smpcTick, smpcResetN;
	logic masterReleaseN, sshAckN, scuAckN;
	dataT cpuReadData;
	logic cpuWaitN;
	waitCntT dbgWaitCnt;
	logic dbgHook;

	// Reference model state
	logic expPhase, expTick, expResetN, expHook;
	int riseCount;
	busOwnerE expOwner;
	waitCntT expCnt;
	logic expRise, expFall, expSshAckN, expScuAckN, expReleaseN, expMemSel, expWaitN;
	dataT expRead;
	int cycleCount = 0;

	saturnGlue UUT (.*);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	task automatic abortRun();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic reportMismatch(string name, logic [31:0] exp, logic [31:0] act);
		$display("ERROR at %0t: %s expected %0h, got %0h", $time, name, exp, act);
		abortRun();
	endtask

	task automatic reportConflict(string what);
		$display("ERROR at %0t: %s", $time, what);
		abortRun();
	endtask

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == timeoutCycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeoutCycles);
			abortRun();
		end
	end

	assign expRise = expPhase && !pauseEn;
	assign expFall = !expPhase && !pauseEn;
	assign expSshAckN = !(expOwner == ownerSlave && !masterGrantN);
	assign expScuAckN = !(expOwner == ownerScu && !masterGrantN);
	assign expReleaseN = !((expOwner == ownerSlave && !sshBusReqN) ||
	                       (expOwner == ownerScu && !scuBusReqN));
	assign expMemSel = !cs3N || !lowRamSelN || !romSelN || !sramSelN;
	assign expWaitN = scuWaitN && (memWaitN || !expMemSel);

	always_comb begin
		if (expMemSel) begin
			expRead = memDi;
		end else if (!smpcSelN) begin
			expRead = {smpcDo, smpcDo, smpcDo, smpcDo};
		end else begin
			expRead = scuDo;
		end
	end

	always @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			expPhase  <= 1'b0;
			riseCount <= 0;
			expTick   <= 1'b0;
			expResetN <= 1'b0;
			expOwner  <= ownerMaster;
			expCnt    <= '0;
			expHook   <= 1'b0;
		end else begin
			if (ce && !pauseEn) expPhase <= !expPhase;
			expTick <= 1'b0;
			if (expTick) expResetN <= 1'b1;
			if (expRise) begin
				if (riseCount == smpcDivide - 1) begin
					riseCount <= 0;
					expTick   <= 1'b1;
				end else begin
					riseCount <= riseCount + 1;
				end
				// Slave wins from idle and owners are never preempted
				if (expOwner == ownerMaster) begin
					if (!sshBusReqN) expOwner <= ownerSlave;
					else if (!scuBusReqN) expOwner <= ownerScu;
				end else if (expOwner == ownerSlave && sshBusReqN) begin
					expOwner <= ownerMaster;
				end else if (expOwner == ownerScu && scuBusReqN) begin
					expOwner <= ownerMaster;
				end
				expCnt <= (!cpuRdN || cpuDqmN != 4'hF) ? expCnt + 8'd1 : 8'd0;
				if (cpuAddr == hookAddr && !cpuRdN && !cs3N) expHook <= 1'b1;
			end
		end
	end

	// Outputs are settled at the falling edge
	assert property (@(negedge CLK) disable iff (!RST_N) ceRise == expRise)
		else reportMismatch("ceRise", 32'(expRise), 32'(ceRise));
	assert property (@(negedge CLK) disable iff (!RST_N) ceFall == expFall)
		else reportMismatch("ceFall", 32'(expFall), 32'(ceFall));
	assert property (@(negedge CLK) disable iff (!RST_N) pauseEn || (ceRise != ceFall))
		else reportConflict("ceRise and ceFall are not complements while running");
	assert property (@(negedge CLK) disable iff (!RST_N) smpcTick == expTick)
		else reportMismatch("smpcTick", 32'(expTick), 32'(smpcTick));
	assert property (@(negedge CLK) disable iff (!RST_N) smpcResetN == expResetN)
		else reportMismatch("smpcResetN", 32'(expResetN), 32'(smpcResetN));
	assert property (@(negedge CLK) disable iff (!RST_N) sshAckN == expSshAckN)
		else reportMismatch("sshAckN", 32'(expSshAckN), 32'(sshAckN));
	assert property (@(negedge CLK) disable iff (!RST_N) scuAckN == expScuAckN)
		else reportMismatch("scuAckN", 32'(expScuAckN), 32'(scuAckN));
	assert property (@(negedge CLK) disable iff (!RST_N) sshAckN || scuAckN)
		else reportConflict("slave CPU and SCU are both acknowledged");
	assert property (@(negedge CLK) disable iff (!RST_N) masterReleaseN == expReleaseN)
		else reportMismatch("masterReleaseN", 32'(expReleaseN), 32'(masterReleaseN));
	assert property (@(negedge CLK) disable iff (!RST_N) cpuReadData == expRead)
		else reportMismatch("cpuReadData", expRead, cpuReadData);
	assert property (@(negedge CLK) disable iff (!RST_N) cpuWaitN == expWaitN)
		else reportMismatch("cpuWaitN", 32'(expWaitN), 32'(cpuWaitN));
	assert property (@(negedge CLK) disable iff (!RST_N) dbgWaitCnt == expCnt)
		else reportMismatch("dbgWaitCnt", 32'(expCnt), 32'(dbgWaitCnt));
	assert property (@(negedge CLK) disable iff (!RST_N) dbgHook == expHook)
		else reportMismatch("dbgHook", 32'(expHook), 32'(dbgHook));

	task automatic nextCycle();
		@(posedge CLK);
		#2;
	endtask

	task automatic holdCycles(int n);
		repeat (n) nextCycle();
	endtask

	task automatic randomEnables(int n);
		repeat (n) begin
			nextCycle();
			ce      = ($urandom % 4) != 0;
			pauseEn = ($urandom % 5) == 0;
		end
	endtask

	// Requests flip rarely so that owners hold the bus for a while
	task automatic randomArbitration(int n);
		repeat (n) begin
			nextCycle();
			if ($urandom % 8 == 0) sshBusReqN = !sshBusReqN;
			if ($urandom % 6 == 0) scuBusReqN = !scuBusReqN;
			masterGrantN = ($urandom % 3) == 0;
		end
	endtask

	task automatic randomRouting(int n);
		repeat (n) begin
			nextCycle();
			cs3N       = ($urandom % 4) != 0;
			lowRamSelN = ($urandom % 4) != 0;
			romSelN    = ($urandom % 4) != 0;
			sramSelN   = ($urandom % 4) != 0;
			smpcSelN   = ($urandom % 2) != 0;
			memDi      = dataT'($urandom);
			scuDo      = dataT'($urandom);
			smpcDo     = smpcDataT'($urandom);
			memWaitN   = ($urandom % 3) != 0;
			scuWaitN   = ($urandom % 3) != 0;
			cpuAddr    = addrT'($urandom);
			cpuRdN     = ($urandom % 2) != 0;
			cpuDqmN    = dqmT'($urandom);
		end
	endtask

	initial begin
		void'($urandom(66));
		RST_N = 1'b0;
		ce = 1'b0;
		pauseEn = 1'b0;
		sshBusReqN = 1'b1;
		scuBusReqN = 1'b1;
		masterGrantN = 1'b1;
		cpuAddr = '0;
		cpuRdN = 1'b1;
		cpuDqmN = 4'hF;
		cs3N = 1'b1;
		lowRamSelN = 1'b1;
		romSelN = 1'b1;
		sramSelN = 1'b1;
		smpcSelN = 1'b1;
		memDi = '0;
		scuDo = '0;
		smpcDo = '0;
		memWaitN = 1'b1;
		scuWaitN = 1'b1;
		holdCycles(3);
		RST_N = 1'b1;

		ce = 1'b1;
		holdCycles(20);
		pauseEn = 1'b1;
		holdCycles(10);
		pauseEn = 1'b0;
		holdCycles(10);
		randomEnables(300);

		ce = 1'b1;
		pauseEn = 1'b0;
		masterGrantN = 1'b0;
		holdCycles(4);
		// Both ask from an idle bus
		sshBusReqN = 1'b0;
		scuBusReqN = 1'b0;
		while (sshAckN) nextCycle();
		holdCycles(6);
		sshBusReqN = 1'b1;
		while (scuAckN) nextCycle();
		holdCycles(6);
		scuBusReqN = 1'b1;
		randomArbitration(400);

		randomRouting(300);

		ce = 1'b1;
		pauseEn = 1'b0;
		cs3N = 1'b1;
		cpuAddr = hookAddr + addrT'(4);
		cpuRdN = 1'b0;
		cpuDqmN = 4'hF;
		holdCycles(600);
		cpuRdN = 1'b1;
		holdCycles(10);
		cpuAddr = hookAddr;
		cpuRdN = 1'b0;
		holdCycles(10);
		cs3N = 1'b0;
		holdCycles(10);
		cpuAddr = '0;
		cpuRdN = 1'b1;
		cs3N = 1'b1;
		holdCycles(10);

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
common/saturnPkg.sv
common/cpuBusIf.sv
verilog/clockEnables.sv
bus/busArbiter.sv
bus/busRouter.sv
verilog/debugMonitor.sv
verilog/saturnGlue.sv
test/tbSaturnGlue.sv

/* run.sh */
#!/bin/sh
# Build and run the saturnGlue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
	-f compile.f \
	--top-module tbSaturnGlue \
	-o simSaturnGlue

./obj_dir/simSaturnGlue
